/* wb_width_pkg.sv */
package wb_width_pkg;

   // Datapath word
   localparam int data_w = 32;

   // Word-aligned PC drops the two low address bits
   localparam int pc_w = 30;

   // Register file has 32 entries
   localparam int reg_aw = 5;

   // One-hot branch opcode bus
   localparam int bru_opc_w = 8;

   typedef logic [data_w-1:0]    data_t;
   typedef logic [pc_w-1:0]      pc_t;
   typedef logic [reg_aw-1:0]    reg_addr_t;
   typedef logic [bru_opc_w-1:0] bru_opc_t;

endpackage

/* wb_commit_pkg.sv */
package wb_commit_pkg;

   // Number of exception events reported by the EPU
   localparam int exc_w = 7;

   typedef logic [exc_w-1:0] exc_vec_t;

   // Event positions inside exc_vec_t
   localparam int exc_eret      = 0;
   localparam int exc_esyscall  = 1;
   localparam int exc_einsn     = 2;
   localparam int exc_eipf      = 3;
   localparam int exc_eitm      = 4;
   localparam int exc_eirq      = 5;
   localparam int exc_flush_tlb = 6;

   // Relative jump bit in the BRU opcode bus
   localparam int bru_jmprel_bit = 0;

endpackage

/* wb_result_mux.sv */
module wb_result_mux (
   input  logic                alu_1_valid,
   input  wb_width_pkg::data_t alu_1_dout,
   input  logic                alu_2_valid,
   input  wb_width_pkg::data_t alu_2_dout,
   input  logic                bru_valid,
   input  wb_width_pkg::data_t bru_dout,
   input  logic                bru_in_slot_1,
   input  logic                lpu_valid,
   input  wb_width_pkg::data_t lpu_dout,
   input  logic                lpu_in_slot_1,
   input  logic                epu_valid,
   input  wb_width_pkg::data_t epu_dout,
   input  logic                epu_in_slot_1,
   input  logic                lsu_valid,
   input  logic                lsu_in_slot_1,
   input  logic                slot_2_in_pred_path,
   output logic                byp_valid_1,
   output logic                byp_valid_2,
   output wb_width_pkg::data_t byp_dout_1,
   output wb_width_pkg::data_t byp_dout_2,
   output logic                res_valid_2,
   output logic                slot_occ_1,
   output logic                slot_occ_2
);

   localparam int dw = wb_width_pkg::data_w;

   logic bru_sel_1, bru_sel_2;
   logic lpu_sel_1, lpu_sel_2;
   logic epu_sel_1, epu_sel_2;

   // Shared units pick a slot by their in_slot_1 select
   assign bru_sel_1 = bru_valid & bru_in_slot_1;
   assign bru_sel_2 = bru_valid & ~bru_in_slot_1;
   assign lpu_sel_1 = lpu_valid & lpu_in_slot_1;
   assign lpu_sel_2 = lpu_valid & ~lpu_in_slot_1;
   assign epu_sel_1 = epu_valid & epu_in_slot_1;
   assign epu_sel_2 = epu_valid & ~epu_in_slot_1;

   // Units that return a result in this stage
   assign byp_valid_1 = alu_1_valid | bru_sel_1 | lpu_sel_1 | epu_sel_1;
   assign res_valid_2 = alu_2_valid | bru_sel_2 | lpu_sel_2 | epu_sel_2;

   // Slot 2 is only bypassed when it lies on the predicted path
   assign byp_valid_2 = res_valid_2 & slot_2_in_pred_path;

   // A memory access also occupies its slot, though its data comes later
   assign slot_occ_1 = byp_valid_1 | (lsu_valid & lsu_in_slot_1);
   assign slot_occ_2 = res_valid_2 | (lsu_valid & ~lsu_in_slot_1);

   // At most one claimer per slot, so masked OR acts as a one-hot mux
   assign byp_dout_1 = (alu_1_dout & {dw{alu_1_valid}}) |
                       (bru_dout & {dw{bru_sel_1}}) |
                       (lpu_dout & {dw{lpu_sel_1}}) |
                       (epu_dout & {dw{epu_sel_1}});

   assign byp_dout_2 = (alu_2_dout & {dw{alu_2_valid}}) |
                       (bru_dout & {dw{bru_sel_2}}) |
                       (lpu_dout & {dw{lpu_sel_2}}) |
                       (epu_dout & {dw{epu_sel_2}});

endmodule

/* wb_exc_commit.sv */
module wb_exc_commit (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    stall,
   input  logic                    flush,
   input  logic                    epu_valid,
   input  wb_commit_pkg::exc_vec_t epu_exc,
   input  logic                    epu_in_slot_1,
   output wb_commit_pkg::exc_vec_t commit_slot_1,
   output wb_commit_pkg::exc_vec_t commit_slot_2,
   output logic                    epu_commit_valid
);

   logic take;

   // Events only count with a live EPU result that is not being flushed
   assign take = epu_valid & ~flush;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         commit_slot_1    <= '0;
         commit_slot_2    <= '0;
         epu_commit_valid <= 1'b0;
      end
      else if (!stall)
      begin
         epu_commit_valid <= take;
         // Flags go to the slot the EPU served and the other slot reads zero
         if (take && epu_in_slot_1)
            commit_slot_1 <= epu_exc;
         else
            commit_slot_1 <= '0;
         if (take && !epu_in_slot_1)
            commit_slot_2 <= epu_exc;
         else
            commit_slot_2 <= '0;
      end
   end

endmodule

/* wb_bru_capture.sv */
module wb_bru_capture #(
   parameter int bpu_upd_w = 16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   stall,
   input  logic                   flush,
   input  logic                   bru_valid,
   input  logic                   bru_in_slot_1,
   input  logic                   bru_is_bcc,
   input  logic                   bru_is_breg,
   input  wb_width_pkg::pc_t      slot_1_pc,
   input  wb_width_pkg::pc_t      slot_2_pc,
   input  logic [bpu_upd_w-1:0]   slot_1_bpu_upd,
   input  logic [bpu_upd_w-1:0]   slot_2_bpu_upd,
   input  wb_width_pkg::bru_opc_t bru_opc,
   output logic                   bpu_wb_valid,
   output logic                   bpu_wb_is_bcc,
   output logic                   bpu_wb_is_breg,
   output logic                   bpu_wb_en,
   output wb_width_pkg::pc_t      bpu_wb_pc,
   output logic [bpu_upd_w-1:0]   bpu_wb_upd
);

   wb_width_pkg::pc_t    br_pc;
   logic [bpu_upd_w-1:0] br_upd;

   // PC and update record of the slot holding the branch
   assign br_pc  = bru_in_slot_1 ? slot_1_pc : slot_2_pc;
   assign br_upd = bru_in_slot_1 ? slot_1_bpu_upd : slot_2_bpu_upd;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         bpu_wb_valid <= 1'b0;
      else if (!stall)
         bpu_wb_valid <= bru_valid & ~flush;
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         bpu_wb_pc      <= br_pc;
         bpu_wb_upd     <= br_upd;
         bpu_wb_is_bcc  <= bru_is_bcc;
         bpu_wb_is_breg <= bru_is_breg;
         // Relative jumps are resolved by predecode and never train the BPU
         bpu_wb_en      <= ~bru_opc[wb_commit_pkg::bru_jmprel_bit];
      end
   end

endmodule

/* wb_slot_reg.sv */
module wb_slot_reg (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    stall,
   input  logic                    flush,
   input  logic                    res_valid_1,
   input  logic                    res_valid_2,
   input  wb_width_pkg::data_t     res_dout_1,
   input  wb_width_pkg::data_t     res_dout_2,
   input  logic                    slot_occ_1,
   input  logic                    slot_occ_2,
   input  logic                    slot_1_rd_we,
   input  logic                    slot_2_rd_we,
   input  wb_width_pkg::reg_addr_t slot_1_rd_addr,
   input  wb_width_pkg::reg_addr_t slot_2_rd_addr,
   input  logic                    lsu_in_slot_1,
   output logic                    s1o_valid_1,
   output logic                    s1o_valid_2,
   output wb_width_pkg::data_t     s1o_dout_1,
   output wb_width_pkg::data_t     s1o_dout_2,
   output logic                    s1o_rd_we_1,
   output logic                    s1o_rd_we_2,
   output wb_width_pkg::reg_addr_t s1o_rd_addr_1,
   output wb_width_pkg::reg_addr_t s1o_rd_addr_2,
   output logic                    lsu_rd_we,
   output wb_width_pkg::reg_addr_t lsu_rd_addr
);

   logic                    lsu_we_nxt;
   wb_width_pkg::reg_addr_t lsu_addr_nxt;

   // Destination of the slot that carries the memory access
   assign lsu_we_nxt   = lsu_in_slot_1 ? slot_1_rd_we : slot_2_rd_we;
   assign lsu_addr_nxt = lsu_in_slot_1 ? slot_1_rd_addr : slot_2_rd_addr;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         s1o_valid_1 <= 1'b0;
         s1o_valid_2 <= 1'b0;
         lsu_rd_we   <= 1'b0;
      end
      else if (!stall)
      begin
         s1o_valid_1 <= res_valid_1 & ~flush;
         s1o_valid_2 <= res_valid_2 & ~flush;
         lsu_rd_we   <= lsu_we_nxt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         s1o_dout_1    <= res_dout_1;
         s1o_dout_2    <= res_dout_2;
         // Empty slots never request a register write
         s1o_rd_we_1   <= slot_1_rd_we & slot_occ_1;
         s1o_rd_we_2   <= slot_2_rd_we & slot_occ_2;
         s1o_rd_addr_1 <= slot_1_rd_addr;
         s1o_rd_addr_2 <= slot_2_rd_addr;
         lsu_rd_addr   <= lsu_addr_nxt;
      end
   end

endmodule

/* wb_buf_top.sv */
module wb_buf_top #(
   parameter int bpu_upd_w = 16
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    stall,
   input  logic                    flush,
   // Scheduler
   input  wb_width_pkg::pc_t       slot_1_pc,
   input  wb_width_pkg::pc_t       slot_2_pc,
   input  logic                    slot_1_rd_we,
   input  logic                    slot_2_rd_we,
   input  wb_width_pkg::reg_addr_t slot_1_rd_addr,
   input  wb_width_pkg::reg_addr_t slot_2_rd_addr,
   input  logic [bpu_upd_w-1:0]    slot_1_bpu_upd,
   input  logic [bpu_upd_w-1:0]    slot_2_bpu_upd,
   input  logic                    slot_2_in_pred_path,
   input  logic                    lsu_valid,
   input  logic                    lsu_in_slot_1,
   // Functional units
   input  logic                    alu_1_valid,
   input  wb_width_pkg::data_t     alu_1_dout,
   input  logic                    alu_2_valid,
   input  wb_width_pkg::data_t     alu_2_dout,
   input  logic                    bru_valid,
   input  wb_width_pkg::data_t     bru_dout,
   input  logic                    bru_in_slot_1,
   input  logic                    bru_is_bcc,
   input  logic                    bru_is_breg,
   input  wb_width_pkg::bru_opc_t  bru_opc,
   input  logic                    lpu_valid,
   input  wb_width_pkg::data_t     lpu_dout,
   input  logic                    lpu_in_slot_1,
   input  logic                    epu_valid,
   input  wb_width_pkg::data_t     epu_dout,
   input  logic                    epu_in_slot_1,
   input  wb_commit_pkg::exc_vec_t epu_exc,
   // Bypass network
   output logic                    byp_valid_1,
   output logic                    byp_valid_2,
   output wb_width_pkg::data_t     byp_dout_1,
   output wb_width_pkg::data_t     byp_dout_2,
   // Next stage
   output logic                    s1o_valid_1,
   output logic                    s1o_valid_2,
   output wb_width_pkg::data_t     s1o_dout_1,
   output wb_width_pkg::data_t     s1o_dout_2,
   output logic                    s1o_rd_we_1,
   output logic                    s1o_rd_we_2,
   output wb_width_pkg::reg_addr_t s1o_rd_addr_1,
   output wb_width_pkg::reg_addr_t s1o_rd_addr_2,
   output logic                    lsu_rd_we,
   output wb_width_pkg::reg_addr_t lsu_rd_addr,
   output wb_commit_pkg::exc_vec_t commit_slot_1,
   output wb_commit_pkg::exc_vec_t commit_slot_2,
   output logic                    epu_commit_valid,
   // Branch predictor update
   output logic                    bpu_wb_valid,
   output logic                    bpu_wb_is_bcc,
   output logic                    bpu_wb_is_breg,
   output logic                    bpu_wb_en,
   output wb_width_pkg::pc_t       bpu_wb_pc,
   output logic [bpu_upd_w-1:0]    bpu_wb_upd
);

   logic res_valid_2;
   logic slot_occ_1;
   logic slot_occ_2;

   wb_result_mux result_mux_i (
      .alu_1_valid         (alu_1_valid),
      .alu_1_dout          (alu_1_dout),
      .alu_2_valid         (alu_2_valid),
      .alu_2_dout          (alu_2_dout),
      .bru_valid           (bru_valid),
      .bru_dout            (bru_dout),
      .bru_in_slot_1       (bru_in_slot_1),
      .lpu_valid           (lpu_valid),
      .lpu_dout            (lpu_dout),
      .lpu_in_slot_1       (lpu_in_slot_1),
      .epu_valid           (epu_valid),
      .epu_dout            (epu_dout),
      .epu_in_slot_1       (epu_in_slot_1),
      .lsu_valid           (lsu_valid),
      .lsu_in_slot_1       (lsu_in_slot_1),
      .slot_2_in_pred_path (slot_2_in_pred_path),
      .byp_valid_1         (byp_valid_1),
      .byp_valid_2         (byp_valid_2),
      .byp_dout_1          (byp_dout_1),
      .byp_dout_2          (byp_dout_2),
      .res_valid_2         (res_valid_2),
      .slot_occ_1          (slot_occ_1),
      .slot_occ_2          (slot_occ_2)
   );

   wb_exc_commit exc_commit_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .stall            (stall),
      .flush            (flush),
      .epu_valid        (epu_valid),
      .epu_exc          (epu_exc),
      .epu_in_slot_1    (epu_in_slot_1),
      .commit_slot_1    (commit_slot_1),
      .commit_slot_2    (commit_slot_2),
      .epu_commit_valid (epu_commit_valid)
   );

   wb_bru_capture #(
      .bpu_upd_w (bpu_upd_w)
   ) bru_capture_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .stall          (stall),
      .flush          (flush),
      .bru_valid      (bru_valid),
      .bru_in_slot_1  (bru_in_slot_1),
      .bru_is_bcc     (bru_is_bcc),
      .bru_is_breg    (bru_is_breg),
      .slot_1_pc      (slot_1_pc),
      .slot_2_pc      (slot_2_pc),
      .slot_1_bpu_upd (slot_1_bpu_upd),
      .slot_2_bpu_upd (slot_2_bpu_upd),
      .bru_opc        (bru_opc),
      .bpu_wb_valid   (bpu_wb_valid),
      .bpu_wb_is_bcc  (bpu_wb_is_bcc),
      .bpu_wb_is_breg (bpu_wb_is_breg),
      .bpu_wb_en      (bpu_wb_en),
      .bpu_wb_pc      (bpu_wb_pc),
      .bpu_wb_upd     (bpu_wb_upd)
   );

   // Slot 1 registers the bypass result as is, slot 2 takes the ungated valid
   wb_slot_reg slot_reg_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .stall          (stall),
      .flush          (flush),
      .res_valid_1    (byp_valid_1),
      .res_valid_2    (res_valid_2),
      .res_dout_1     (byp_dout_1),
      .res_dout_2     (byp_dout_2),
      .slot_occ_1     (slot_occ_1),
      .slot_occ_2     (slot_occ_2),
      .slot_1_rd_we   (slot_1_rd_we),
      .slot_2_rd_we   (slot_2_rd_we),
      .slot_1_rd_addr (slot_1_rd_addr),
      .slot_2_rd_addr (slot_2_rd_addr),
      .lsu_in_slot_1  (lsu_in_slot_1),
      .s1o_valid_1    (s1o_valid_1),
      .s1o_valid_2    (s1o_valid_2),
      .s1o_dout_1     (s1o_dout_1),
      .s1o_dout_2     (s1o_dout_2),
      .s1o_rd_we_1    (s1o_rd_we_1),
      .s1o_rd_we_2    (s1o_rd_we_2),
      .s1o_rd_addr_1  (s1o_rd_addr_1),
      .s1o_rd_addr_2  (s1o_rd_addr_2),
      .lsu_rd_we      (lsu_rd_we),
      .lsu_rd_addr    (lsu_rd_addr)
   );

endmodule

/* wb_buf_chk.sv */
module wb_buf_chk (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    stall,
   input logic                    flush,
   input logic                    s1o_valid_1,
   input logic                    s1o_valid_2,
   input wb_width_pkg::data_t     s1o_dout_1,
   input wb_width_pkg::data_t     s1o_dout_2,
   input wb_width_pkg::reg_addr_t lsu_rd_addr,
   input wb_commit_pkg::exc_vec_t commit_slot_1,
   input wb_commit_pkg::exc_vec_t commit_slot_2,
   input logic                    epu_commit_valid,
   input logic                    bpu_wb_valid,
   input wb_width_pkg::pc_t       bpu_wb_pc
);

   int assert_fails = 0;

   // A loading flush empties the stage
   flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
      (flush && !stall) |=> (!s1o_valid_1 && !s1o_valid_2 && commit_slot_1 == '0 &&
                             commit_slot_2 == '0 && !epu_commit_valid && !bpu_wb_valid))
   else
   begin
      assert_fails++;
      $error("valid or commit flag set after a flush");
   end

   // The EPU serves one slot only
   commit_one_slot: assert property (@(posedge clk) disable iff (!rst_n)
      !(|commit_slot_1 && |commit_slot_2))
   else
   begin
      assert_fails++;
      $error("commit flags set for both slots");
   end

   stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
      stall |=> ($stable(s1o_valid_1) && $stable(s1o_valid_2) && $stable(s1o_dout_1) &&
                 $stable(s1o_dout_2) && $stable(lsu_rd_addr) && $stable(commit_slot_1) &&
                 $stable(commit_slot_2) && $stable(bpu_wb_valid) && $stable(bpu_wb_pc)))
   else
   begin
      assert_fails++;
      $error("registered output changed during a stall");
   end

endmodule

bind wb_buf_top wb_buf_chk assert_i (.*);

/* wb_buf_checker.sv */
module wb_buf_checker (
   input  logic         clk,
   input  logic         rst_n,
   input  int           byp_test,
   input  int           reg_test,
   input  logic [214:0] exp_vec,
   input  logic [214:0] act_vec,
   output int           err_count,
   output int           check_count
);

   localparam int n_fields = 23;

   // Field bounds inside the packed port image with the bypass fields first
   localparam int fmsb [n_fields] = '{214, 213, 212, 180, 148, 147, 146, 114, 82, 81, 80, 75,
                                      70, 69, 64, 57, 50, 49, 48, 47, 46, 45, 15};
   localparam int flsb [n_fields] = '{214, 213, 181, 149, 148, 147, 115, 83, 82, 81, 76, 71,
                                      70, 65, 58, 51, 50, 49, 48, 47, 46, 16, 0};

   function automatic string field_name(input int i);
      case (i)
         0: return "byp_valid_1";
         1: return "byp_valid_2";
         2: return "byp_dout_1";
         3: return "byp_dout_2";
         4: return "s1o_valid_1";
         5: return "s1o_valid_2";
         6: return "s1o_dout_1";
         7: return "s1o_dout_2";
         8: return "s1o_rd_we_1";
         9: return "s1o_rd_we_2";
         10: return "s1o_rd_addr_1";
         11: return "s1o_rd_addr_2";
         12: return "lsu_rd_we";
         13: return "lsu_rd_addr";
         14: return "commit_slot_1";
         15: return "commit_slot_2";
         16: return "epu_commit_valid";
         17: return "bpu_wb_valid";
         18: return "bpu_wb_is_bcc";
         19: return "bpu_wb_is_breg";
         20: return "bpu_wb_en";
         21: return "bpu_wb_pc";
         default: return "bpu_wb_upd";
      endcase
   endfunction

   function automatic string test_name(input int id);
      case (id)
         1: return "bypass";
         2: return "pred_path";
         3: return "flush_stall";
         4: return "exception";
         5: return "branch";
         6: return "lsu_dest";
         7: return "random";
         default: return "idle";
      endcase
   endfunction

   initial
   begin
      err_count   = 0;
      check_count = 0;
   end

   always @(posedge clk)
   begin : compare
      logic [63:0] mask;
      logic [63:0] ev;
      logic [63:0] av;
      int          w;
      if (rst_n)
      begin
         for (int i = 0; i < n_fields; i++)
         begin
            w    = fmsb[i] - flsb[i] + 1;
            mask = (64'd1 << w) - 64'd1;
            ev   = 64'(exp_vec >> flsb[i]) & mask;
            av   = 64'(act_vec >> flsb[i]) & mask;
            check_count++;
            if (av !== ev)
            begin
               err_count++;
               $display("ERROR %s: %s expected %h actual %h",
                        test_name(i < 4 ? byp_test : reg_test), field_name(i), ev, av);
            end
         end
      end
   end

endmodule

/* wb_buf_tb.sv */
module wb_buf_tb;

   localparam int upd_w        = 16;
   localparam int n_phases     = 7;
   localparam int phase_cycles = 40;
   localparam int run_cycles   = 5 + n_phases * phase_cycles + 4;

   logic clk, rst_n, stall, flush;
   wb_width_pkg::pc_t       slot_1_pc, slot_2_pc;
   logic                    slot_1_rd_we, slot_2_rd_we;
   wb_width_pkg::reg_addr_t slot_1_rd_addr, slot_2_rd_addr;
   logic [upd_w-1:0]        slot_1_bpu_upd, slot_2_bpu_upd;
   logic                    slot_2_in_pred_path, lsu_valid, lsu_in_slot_1;
   logic                    alu_1_valid, alu_2_valid, bru_valid, lpu_valid, epu_valid;
   wb_width_pkg::data_t     alu_1_dout, alu_2_dout, bru_dout, lpu_dout, epu_dout;
   logic                    bru_in_slot_1, lpu_in_slot_1, epu_in_slot_1;
   logic                    bru_is_bcc, bru_is_breg;
   wb_width_pkg::bru_opc_t  bru_opc;
   wb_commit_pkg::exc_vec_t epu_exc;

   logic byp_valid_1, byp_valid_2, s1o_valid_1, s1o_valid_2, s1o_rd_we_1, s1o_rd_we_2;
   logic lsu_rd_we, epu_commit_valid, bpu_wb_valid, bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_en;
   wb_width_pkg::data_t     byp_dout_1, byp_dout_2, s1o_dout_1, s1o_dout_2;
   wb_width_pkg::reg_addr_t s1o_rd_addr_1, s1o_rd_addr_2, lsu_rd_addr;
   wb_commit_pkg::exc_vec_t commit_slot_1, commit_slot_2;
   wb_width_pkg::pc_t       bpu_wb_pc;
   logic [upd_w-1:0]        bpu_wb_upd;

   int           seed = 54;
   int           test_id, reg_test_id, err_count, check_count, total_err;
   logic [65:0]  exp_byp;
   logic [148:0] model;
   logic [214:0] act_vec;

   wb_buf_top #(.bpu_upd_w(upd_w)) dut_i (.*);

   assign act_vec = {byp_valid_1, byp_valid_2, byp_dout_1, byp_dout_2, s1o_valid_1, s1o_valid_2,
                     s1o_dout_1, s1o_dout_2, s1o_rd_we_1, s1o_rd_we_2, s1o_rd_addr_1,
                     s1o_rd_addr_2, lsu_rd_we, lsu_rd_addr, commit_slot_1, commit_slot_2,
                     epu_commit_valid, bpu_wb_valid, bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_en,
                     bpu_wb_pc, bpu_wb_upd};

   wb_buf_checker chk_i (.clk(clk), .rst_n(rst_n), .byp_test(test_id), .reg_test(reg_test_id),
                         .exp_vec({exp_byp, model}), .act_vec(act_vec),
                         .err_count(err_count), .check_count(check_count));

   // Raw slot claims as {valid_1, valid_2, dout_1, dout_2} before the slot 2 gating
   function automatic logic [65:0] slot_claims();
      logic v1, v2;
      wb_width_pkg::data_t d1, d2;
      v1 = alu_1_valid;
      v2 = alu_2_valid;
      d1 = alu_1_valid ? alu_1_dout : '0;
      d2 = alu_2_valid ? alu_2_dout : '0;
      if (bru_valid)
      begin
         if (bru_in_slot_1)
            {v1, d1} = {1'b1, bru_dout};
         else
            {v2, d2} = {1'b1, bru_dout};
      end
      if (lpu_valid)
      begin
         if (lpu_in_slot_1)
            {v1, d1} = {1'b1, lpu_dout};
         else
            {v2, d2} = {1'b1, lpu_dout};
      end
      if (epu_valid)
      begin
         if (epu_in_slot_1)
            {v1, d1} = {1'b1, epu_dout};
         else
            {v2, d2} = {1'b1, epu_dout};
      end
      return {v1, v2, d1, d2};
   endfunction

   // Expected registered outputs after the next rising edge
   function automatic logic [148:0] ref_next(input logic [148:0] prev);
      logic [65:0] r;
      logic occ_1, occ_2, ev;
      wb_commit_pkg::exc_vec_t c1, c2;
      if (stall)
         return prev;
      r     = slot_claims();
      occ_1 = r[65] | (lsu_valid & lsu_in_slot_1);
      occ_2 = r[64] | (lsu_valid & ~lsu_in_slot_1);
      ev    = epu_valid & ~flush;
      c1    = (ev && epu_in_slot_1) ? epu_exc : '0;
      c2    = (ev && !epu_in_slot_1) ? epu_exc : '0;
      return {r[65] & ~flush, r[64] & ~flush, r[63:0], slot_1_rd_we & occ_1,
              slot_2_rd_we & occ_2, slot_1_rd_addr, slot_2_rd_addr,
              lsu_in_slot_1 ? slot_1_rd_we : slot_2_rd_we,
              lsu_in_slot_1 ? slot_1_rd_addr : slot_2_rd_addr, c1, c2, ev,
              bru_valid & ~flush, bru_is_bcc, bru_is_breg,
              ~bru_opc[wb_commit_pkg::bru_jmprel_bit],
              bru_in_slot_1 ? slot_1_pc : slot_2_pc,
              bru_in_slot_1 ? slot_1_bpu_upd : slot_2_bpu_upd};
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin : track
      logic [148:0] nxt;
      nxt = ref_next(model);
      // Control flags clear in reset while data still loads
      if (!rst_n)
      begin
         nxt[148:147] = '0;
         nxt[70]      = 1'b0;
         nxt[64:49]   = '0;
      end
      model       <= nxt;
      reg_test_id <= test_id;
   end

   task automatic set_idle();
      {stall, flush, alu_1_valid, alu_2_valid, bru_valid, lpu_valid, epu_valid} = '0;
      {lsu_valid, lsu_in_slot_1, bru_in_slot_1, lpu_in_slot_1, epu_in_slot_1} = '0;
      {bru_is_bcc, bru_is_breg, slot_1_rd_we, slot_2_rd_we} = '0;
      {alu_1_dout, alu_2_dout, bru_dout, lpu_dout, epu_dout} = '0;
      {slot_1_pc, slot_2_pc, slot_1_rd_addr, slot_2_rd_addr} = '0;
      {slot_1_bpu_upd, slot_2_bpu_upd, bru_opc, epu_exc} = '0;
      slot_2_in_pred_path = 1'b1;
      exp_byp = {slot_claims()};
   endtask

   function automatic int pick(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Unit codes for a slot claim are 1 ALU, 2 BRU, 3 LPU, 4 EPU and 0 for none
   task automatic drive_cycle(input int force_unit, input bit force_lsu, input bit pred_rand,
                              input int p_stall, input int p_flush);
      int c1, c2;
      logic [65:0] r;
      @(negedge clk);
      c1 = pick(5);
      c2 = pick(5);
      if (force_unit >= 2)
      begin
         if (pick(2) == 0)
            c1 = force_unit;
         else
            c2 = force_unit;
      end
      if (c1 == c2 && c1 >= 2)
         c2 = 0;
      alu_1_valid   = (c1 == 1);
      alu_2_valid   = (c2 == 1);
      bru_valid     = (c1 == 2) || (c2 == 2);
      lpu_valid     = (c1 == 3) || (c2 == 3);
      epu_valid     = (c1 == 4) || (c2 == 4);
      bru_in_slot_1 = bru_valid ? (c1 == 2) : pick(2);
      lpu_in_slot_1 = lpu_valid ? (c1 == 3) : pick(2);
      epu_in_slot_1 = epu_valid ? (c1 == 4) : pick(2);
      {alu_1_dout, alu_2_dout, bru_dout} = {$random(seed), $random(seed), $random(seed)};
      {lpu_dout, epu_dout} = {$random(seed), $random(seed)};
      {slot_1_pc, slot_2_pc} = {$random(seed), $random(seed)};
      {slot_1_rd_addr, slot_2_rd_addr, slot_1_rd_we, slot_2_rd_we} = $random(seed);
      {slot_1_bpu_upd, slot_2_bpu_upd} = $random(seed);
      {bru_opc, epu_exc, bru_is_bcc, bru_is_breg, lsu_in_slot_1} = $random(seed);
      lsu_valid           = force_lsu ? 1'b1 : pick(2);
      slot_2_in_pred_path = pred_rand ? pick(2) : 1'b0;
      stall               = pick(100) < p_stall;
      flush               = pick(100) < p_flush;
      r                   = slot_claims();
      exp_byp             = {r[65], r[64] & slot_2_in_pred_path, r[63:0]};
   endtask

   task automatic run_phase(input int id, input int force_unit, input bit force_lsu,
                            input bit pred_rand, input int p_stall, input int p_flush);
      test_id = id;
      repeat (phase_cycles)
         drive_cycle(force_unit, force_lsu, pred_rand, p_stall, p_flush);
   endtask

   initial
   begin
      test_id     = 0;
      reg_test_id = 0;
      rst_n       = 1'b0;
      set_idle();
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      run_phase(1, 0, 1'b0, 1'b1, 0, 0);
      run_phase(2, 0, 1'b0, 1'b0, 0, 0);
      run_phase(3, 0, 1'b0, 1'b1, 25, 25);
      run_phase(4, 4, 1'b0, 1'b1, 0, 10);
      run_phase(5, 2, 1'b0, 1'b1, 0, 0);
      run_phase(6, 0, 1'b1, 1'b1, 10, 0);
      run_phase(7, 0, 1'b0, 1'b1, 15, 15);
      @(negedge clk);
      test_id = 0;
      set_idle();
      repeat (2) @(negedge clk);
      total_err = err_count + dut_i.assert_i.assert_fails;
      $display("checks %0d, value errors %0d, assertion failures %0d",
               check_count, err_count, dut_i.assert_i.assert_fails);
      if (total_err == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // Bounded by the stimulus length with some margin
   initial
   begin
      #((run_cycles + 50) * 10);
      $display("Watchdog expired before the stimulus finished");
      $display("TESTS FAILED");
      $finish;
   end

endmodule

/* build.f */
wb_width_pkg.sv
wb_commit_pkg.sv
wb_result_mux.sv
wb_exc_commit.sv
wb_bru_capture.sv
wb_slot_reg.sv
wb_buf_top.sv
wb_buf_chk.sv
wb_buf_checker.sv
wb_buf_tb.sv
